//--- include/video_timing_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster timing constants for the video timing generator
// include wherever positions, widths or register addresses are needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef VIDEO_TIMING_CONFIG_SVH
`define VIDEO_TIMING_CONFIG_SVH

`define CLK_PER_CEND 4 // master clk cycles per 7 MHz strobe

// horizontal positions, in cend cycles
`define HPERIOD   448
`define HBLNK_BEG 0
`define HSYNC_BEG 10
`define HSYNC_END 43
`define HBLNK_END 84
`define HPIX_BEG  148 // 64 cycles after line_start
`define HPIX_END  404
`define HINT_BEG  3

// vertical positions, in lines
`define VPERIOD   320
`define VBLNK_BEG 0
`define VSYNC_BEG 2
`define VSYNC_END 4
`define VBLNK_END 16
`define VPIX_BEG  80
`define VPIX_END  272
`define INT_LINE  0

`define INT_LEN  32 // frame interrupt width in cend cycles
`define HCOUNT_W 9
`define VCOUNT_W 9
`define FRAME_W  16

// register byte addresses
`define REG_CTRL   0
`define REG_FRAME  4
`define REG_STATUS 8

`endif

//--- rtl/video_timing_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster timing types, shared by the line and frame logic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "video_timing_config.svh"

package video_timing_pkg;

	// counter types sized from the config header
	typedef logic [`HCOUNT_W-1:0] hcount_t; // position within a line
	typedef logic [`VCOUNT_W-1:0] vcount_t; // line within a frame

	// region of the current line, also reported in STATUS
	typedef enum logic [1:0] {
		V_BLANK  = 2'd0, // vertical blank, includes vsync
		V_BORDER = 2'd1, // visible but outside pixel window
		V_ACTIVE = 2'd2  // pixel lines
	} v_region_t;

endpackage

`default_nettype wire

//--- rtl/video_apb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB register interface types for the video timing block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "video_timing_config.svh"

package video_apb_pkg;

	typedef enum logic [3:0] {
		ADDR_CTRL   = 4'(`REG_CTRL),   // int enable, resync
		ADDR_FRAME  = 4'(`REG_FRAME),  // frame counter
		ADDR_STATUS = 4'(`REG_STATUS)  // live region
	} reg_addr_t;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_SETUP,  // psel high, penable low
		PH_ACCESS  // psel and penable high
	} apb_phase_t;

endpackage

`default_nettype wire

//--- rtl/line_strobe_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-line strobes from the horizontal to the vertical generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

interface line_strobe_if;

	logic line_start;  // pulse, one cend before the visible line
	logic hsync_start; // pulse, one cend before hsync rises
	logic hint_start;  // pulse at the interrupt position
	logic hblank;      // level
	logic hpix;        // level, horizontal pixel window

	modport src (output line_start, hsync_start, hint_start, hblank, hpix);
	modport dst (input line_start, hsync_start, hint_start, hblank, hpix);

endinterface

`default_nettype wire

//--- rtl/video_strobes.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// divides clk down to the 7 MHz working strobe cend and its early copy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "video_timing_config.svh"

module video_strobes (
	input  logic clk,
	input  logic reset,
	output logic cend,
	output logic pre_cend // one clk ahead of cend
);

	localparam logic [1:0] LAST_PHASE = 2'(`CLK_PER_CEND - 1);
	localparam logic [1:0] PRE_PHASE  = 2'(`CLK_PER_CEND - 2);

	logic [1:0] phase; // position within one cend period

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase    <= '0;
			cend     <= 1'b0;
			pre_cend <= 1'b0;
		end
		else
		begin
			phase    <= (phase == LAST_PHASE) ? 2'd0 : phase + 2'd1;
			cend     <= (phase == LAST_PHASE); // high while phase is back at 0
			pre_cend <= (phase == PRE_PHASE);
		end
	end

endmodule

`default_nettype wire

//--- rtl/hsync_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// horizontal counter, hsync/hblank/hpix levels and per-line strobes
// levels move on cend, strobes fire on the pre_cend ahead of it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "video_timing_config.svh"

module hsync_gen
	import video_timing_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic init,     // resync pulse, takes effect on the next cend
	input  logic cend,
	input  logic pre_cend,
	output logic hsync,
	line_strobe_if.src strobes
);

	localparam hcount_t LAST_H    = hcount_t'(`HPERIOD - 1);
	localparam hcount_t HBLNK_BEG = hcount_t'(`HBLNK_BEG);
	localparam hcount_t HSYNC_BEG = hcount_t'(`HSYNC_BEG);
	localparam hcount_t HSYNC_END = hcount_t'(`HSYNC_END);
	localparam hcount_t HBLNK_END = hcount_t'(`HBLNK_END);
	localparam hcount_t HPIX_BEG  = hcount_t'(`HPIX_BEG);
	localparam hcount_t HPIX_END  = hcount_t'(`HPIX_END);
	localparam hcount_t HINT_BEG  = hcount_t'(`HINT_BEG);

	hcount_t hcount;
	logic    init_hold; // init seen between two cends

	// init is a single clk wide, hold it until cend samples it
	always_ff @(posedge clk)
	begin
		if (reset)
			init_hold <= 1'b0;
		else if (cend)
			init_hold <= 1'b0; // init on this cend is taken directly
		else if (init)
			init_hold <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			hcount <= '0;
		else if (cend)
		begin
			if (init || init_hold || (hcount == LAST_H))
				hcount <= '0; // new line, or phase realigned
			else
				hcount <= hcount + hcount_t'(1);
		end
	end

	// levels, each one cend behind the matching count
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			strobes.hblank <= 1'b0;
			hsync          <= 1'b0;
			strobes.hpix   <= 1'b0;
		end
		else if (cend)
		begin
			if (hcount == HBLNK_BEG)
				strobes.hblank <= 1'b1;
			else if (hcount == HBLNK_END)
				strobes.hblank <= 1'b0;
			if (hcount == HSYNC_BEG)
				hsync <= 1'b1; // 33 cend wide
			else if (hcount == HSYNC_END)
				hsync <= 1'b0;
			if (hcount == HPIX_BEG)
				strobes.hpix <= 1'b1;
			else if (hcount == HPIX_END)
				strobes.hpix <= 1'b0;
		end
	end

	// pulses coincide with pre_cend, count already holds the match
	assign strobes.line_start  = pre_cend && (hcount == HBLNK_END);
	assign strobes.hsync_start = pre_cend && (hcount == HSYNC_BEG);
	assign strobes.hint_start  = pre_cend && (hcount == HINT_BEG);

endmodule

`default_nettype wire

//--- rtl/vsync_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line counter, vertical blank/sync/pixel window, frame start and interrupt
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "video_timing_config.svh"

module vsync_gen
	import video_timing_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      cend,
	input  logic      int_enable,
	line_strobe_if.dst strobes,
	output logic      vsync,
	output logic      vblank,
	output logic      vpix,
	output logic      int_n,       // frame interrupt, active low
	output logic      frame_start, // one clk as the line count wraps
	output v_region_t v_region
);

	localparam vcount_t LAST_V    = vcount_t'(`VPERIOD - 1);
	localparam vcount_t VBLNK_BEG = vcount_t'(`VBLNK_BEG);
	localparam vcount_t VBLNK_END = vcount_t'(`VBLNK_END);
	localparam vcount_t VSYNC_BEG = vcount_t'(`VSYNC_BEG);
	localparam vcount_t VSYNC_END = vcount_t'(`VSYNC_END);
	localparam vcount_t VPIX_BEG  = vcount_t'(`VPIX_BEG);
	localparam vcount_t VPIX_END  = vcount_t'(`VPIX_END);
	localparam vcount_t INT_LINE  = vcount_t'(`INT_LINE);
	localparam logic [5:0] INT_LAST = 6'(`INT_LEN - 1);

	vcount_t    vcount, vcount_next;
	logic [5:0] int_cnt; // cends since int_n fell
	logic       int_arm; // interrupt requested, starts on next cend

	assign vcount_next = (vcount == LAST_V) ? '0 : vcount + vcount_t'(1);

	// line count and levels all step on hsync_start
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vcount      <= '0;
			vblank      <= 1'b0;
			vsync       <= 1'b0;
			vpix        <= 1'b0;
			frame_start <= 1'b0;
		end
		else
		begin
			frame_start <= 1'b0;
			if (strobes.hsync_start)
			begin
				vcount      <= vcount_next;
				frame_start <= (vcount == LAST_V);
				if (vcount_next == VBLNK_BEG)
					vblank <= 1'b1;
				else if (vcount_next == VBLNK_END)
					vblank <= 1'b0;
				if (vcount_next == VSYNC_BEG)
					vsync <= 1'b1;
				else if (vcount_next == VSYNC_END)
					vsync <= 1'b0;
				if (vcount_next == VPIX_BEG)
					vpix <= 1'b1;
				else if (vcount_next == VPIX_END)
					vpix <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			int_arm <= 1'b0;
			int_n   <= 1'b1;
			int_cnt <= '0;
		end
		else
		begin
			if (strobes.hint_start && int_enable && (vcount == INT_LINE))
				int_arm <= 1'b1; // once per frame, at hint position
			if (cend)
			begin
				if (int_arm)
				begin
					int_arm <= 1'b0;
					int_n   <= 1'b0;
					int_cnt <= '0;
				end
				else if (!int_n)
				begin
					int_cnt <= int_cnt + 6'd1;
					if (int_cnt == INT_LAST)
						int_n <= 1'b1; // INT_LEN cends low
				end
			end
		end
	end

	always_comb
	begin
		if (vblank)
			v_region = V_BLANK;
		else if (vpix)
			v_region = V_ACTIVE;
		else
			v_region = V_BORDER;
	end

endmodule

`default_nettype wire

//--- rtl/video_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// zero-wait APB slave: control, frame counter and live status
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "video_timing_config.svh"

module video_regs
	import video_timing_pkg::*;
	import video_apb_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	input  logic        frame_start,
	input  v_region_t   v_region,
	output logic        int_enable,
	output logic        init // resync pulse to the line generator
);

	apb_phase_t bus_phase; // phase of the current cycle
	apb_phase_t phase;     // phase of the previous cycle
	reg_addr_t  addr;
	logic [`FRAME_W-1:0] frame_cnt;
	logic       wr_en;

	assign addr = reg_addr_t'(paddr);

	always_comb
	begin
		if (!psel)
			bus_phase = PH_IDLE;
		else if (penable)
			bus_phase = PH_ACCESS;
		else
			bus_phase = PH_SETUP;
	end

	// access only counts when a setup came before it
	assign wr_en = (bus_phase == PH_ACCESS) && (phase == PH_SETUP) && pwrite;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase      <= PH_IDLE;
			prdata     <= '0;
			int_enable <= 1'b0;
			init       <= 1'b0;
			frame_cnt  <= '0;
		end
		else
		begin
			phase <= bus_phase;
			init  <= 1'b0;
			if (bus_phase == PH_SETUP)
			begin
				case (addr) // read data ready for the access cycle
					ADDR_CTRL:   prdata <= {31'd0, int_enable}; // bit 1 reads 0
					ADDR_FRAME:  prdata <= {{(32-`FRAME_W){1'b0}}, frame_cnt};
					ADDR_STATUS: prdata <= {30'd0, v_region};
					default:     prdata <= '0;
				endcase
			end
			if (wr_en && (addr == ADDR_CTRL))
			begin
				int_enable <= pwdata[0];
				init       <= pwdata[1]; // write one to resync
			end
			if (wr_en && (addr == ADDR_FRAME))
				frame_cnt <= '0; // any write clears
			else if (frame_start)
				frame_cnt <= frame_cnt + `FRAME_W'(1);
		end
	end

endmodule

`default_nettype wire

//--- rtl/video_timing_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster timing generator top, 448-cycle lines and 320-line frames
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module video_timing_top
	import video_timing_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        hsync,
	output logic        vsync,
	output logic        blank,
	output logic        pix,
	output logic        int_n
);

	logic      cend, pre_cend;
	logic      vblank, vpix;
	logic      frame_start;
	logic      init, int_enable;
	v_region_t v_region;

	line_strobe_if strobes ();

	video_strobes u_strobes (.clk, .reset, .cend, .pre_cend);

	hsync_gen u_hsync (
		.clk, .reset, .init, .cend, .pre_cend, .hsync,
		.strobes (strobes.src)
	);

	vsync_gen u_vsync (
		.clk, .reset, .cend, .int_enable,
		.strobes (strobes.dst),
		.vsync, .vblank, .vpix, .int_n, .frame_start, .v_region
	);

	video_regs u_regs (
		.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
		.frame_start, .v_region, .int_enable, .init
	);

	assign blank = strobes.hblank | vblank; // either direction blanks
	assign pix   = strobes.hpix & vpix;     // pixel window in both

endmodule

`default_nettype wire

//--- dv/video_timing_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the raster timing generator
// run through filelist.f, tests run in sequence from reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "video_timing_config.svh"

module video_timing_tb
	import video_timing_pkg::*;
	import video_apb_pkg::*;
();

	localparam int LINE_CLK  = `HPERIOD * `CLK_PER_CEND; // 1792 clk per line
	localparam int FRAME_CLK = `VPERIOD * LINE_CLK;      // 573440 clk per frame
	localparam int HSYNC_CLK = (`HSYNC_END - `HSYNC_BEG) * `CLK_PER_CEND;
	localparam int HBLNK_CLK = (`HBLNK_END - `HBLNK_BEG) * `CLK_PER_CEND;
	localparam int VSYNC_CLK = (`VSYNC_END - `VSYNC_BEG) * LINE_CLK;
	localparam int INT_CLK   = `INT_LEN * `CLK_PER_CEND;
	// pixel window of a frame, and the part that is not blanked
	localparam int PIX_CLK   = (`VPIX_END - `VPIX_BEG) * (`HPIX_END - `HPIX_BEG) * `CLK_PER_CEND;
	localparam int SHOWN_CLK = (`VPERIOD - (`VBLNK_END - `VBLNK_BEG))
		* (`HPERIOD - (`HBLNK_END - `HBLNK_BEG)) * `CLK_PER_CEND;
	// frame test may wait up to four frames, the rest is a few lines
	localparam int TIMEOUT_CYCLES = 3_000_000;

	logic        clk = 1'b0;
	logic        reset;
	logic        psel, penable, pwrite;
	logic [3:0]  paddr;
	logic [31:0] pwdata, prdata;
	logic        hsync, vsync, blank, pix, int_n;

	integer seed = 32'h6537_a926;
	int     clk_cnt = 0;     // posedges since time zero
	int     reset_edge;      // clk_cnt at the last edge with reset high
	int     last_write_edge; // clk_cnt at the edge ending the last write

	video_timing_top dut (
		.clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
		.hsync, .vsync, .blank, .pix, .int_n
	);

	always #4 clk = ~clk;

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Finished with errors");
		$fatal(1);
	endtask

	always @(posedge clk)
	begin
		clk_cnt <= clk_cnt + 1;
		if (clk_cnt >= TIMEOUT_CYCLES)
			stop_run($sformatf("run timed out after %0d clock cycles", TIMEOUT_CYCLES));
	end

	task automatic apb_write(input reg_addr_t addr, input logic [31:0] data);
		@(posedge clk);
		#1 psel = 1'b1; // setup
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#1 penable = 1'b1; // access
		@(posedge clk); // write lands on this edge
		#1 psel = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		last_write_edge = clk_cnt;
	endtask

	task automatic apb_read(input reg_addr_t addr, output logic [31:0] data);
		@(posedge clk);
		#1 psel = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge clk); // prdata registered from setup
		#1 penable = 1'b1;
		@(negedge clk);
		data = prdata;
		@(posedge clk);
		#1 psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_reset_state();
		logic [31:0] rd;
		@(negedge clk); // first cend still 3 clk away
		assert (!hsync && !vsync && !blank && !pix && int_n && prdata == 32'd0)
			else stop_run($sformatf("** Error at %0t: outputs not idle after reset", $time));
		apb_read(ADDR_CTRL, rd);
		assert (rd == 32'd0) else stop_run($sformatf("** Error at %0t: CTRL %h", $time, rd));
		apb_read(ADDR_FRAME, rd);
		assert (rd == 32'd0) else stop_run($sformatf("** Error at %0t: FRAME %h", $time, rd));
		apb_read(ADDR_STATUS, rd); // no vblank, no vpix yet
		assert (rd == 32'(V_BORDER))
			else stop_run($sformatf("** Error at %0t: STATUS %h after reset", $time, rd));
	endtask

	task automatic check_registers();
		logic [31:0] wdata, rd;
		for (int i = 0; i < 8; i++)
		begin
			wdata = $random(seed);
			apb_write(ADDR_CTRL, wdata);
			apb_read(ADDR_CTRL, rd);
			assert (rd == {31'd0, wdata[0]}) // resync bit never reads back
				else stop_run($sformatf("** Error at %0t: CTRL wrote %h read %h",
					$time, wdata, rd));
		end
		apb_write(ADDR_CTRL, 32'd0);
		apb_read(ADDR_STATUS, rd);
		assert (rd[31:2] == 30'd0 && rd[1:0] inside {V_BLANK, V_BORDER, V_ACTIVE})
			else stop_run($sformatf("** Error at %0t: STATUS %h not a region", $time, rd));
	endtask

	// runs after the frame test, so FRAME holds a nonzero count
	task automatic check_frame_clear();
		logic [31:0] wdata, rd;
		wdata = $random(seed);
		apb_write(ADDR_FRAME, wdata);
		apb_read(ADDR_FRAME, rd);
		assert (rd == 32'd0) else stop_run($sformatf("** Error at %0t: FRAME not cleared, %h",
			$time, rd));
	endtask

	task automatic check_line_timing();
		int rise_at;
		@(negedge clk);
		while (hsync) @(negedge clk);
		while (!hsync) @(negedge clk);
		for (int i = 0; i < 3; i++)
		begin
			rise_at = clk_cnt;
			while (hsync) @(negedge clk);
			assert (clk_cnt - rise_at == HSYNC_CLK)
				else stop_run($sformatf("** Error at %0t: hsync high %0d clk", $time,
					clk_cnt - rise_at));
			while (!hsync) @(negedge clk);
			assert (clk_cnt - rise_at == LINE_CLK)
				else stop_run($sformatf("** Error at %0t: line period %0d clk", $time,
					clk_cnt - rise_at));
		end
		while (blank) @(negedge clk); // still in frame 0, vblank stays low
		for (int i = 0; i < 3; i++)
		begin
			while (!blank) @(negedge clk);
			rise_at = clk_cnt;
			while (blank) @(negedge clk);
			assert (clk_cnt - rise_at == HBLNK_CLK)
				else stop_run($sformatf("** Error at %0t: blank high %0d clk", $time,
					clk_cnt - rise_at));
		end
	endtask

	// one frame from vsync rise to vsync rise, line 0 lies inside it
	task automatic watch_frame(input logic int_on);
		int rise_at, fall_at, low_cycles, falls, pix_cycles, shown_cycles;
		logic [31:0] f0, f1;
		logic vs_prev, int_prev;
		@(negedge clk);
		while (vsync) @(negedge clk);
		while (!vsync) @(negedge clk);
		rise_at = clk_cnt;
		apb_read(ADDR_FRAME, f0);
		low_cycles   = 0;
		falls        = 0;
		pix_cycles   = 0;
		shown_cycles = 0; // samples skipped by the read lie in vblank
		fall_at      = rise_at;
		vs_prev      = vsync;
		int_prev     = int_n;
		@(negedge clk);
		while (!(vsync && !vs_prev))
		begin
			if (!vsync && vs_prev)
				fall_at = clk_cnt;
			if (!int_n)
				low_cycles++;
			if (!int_n && int_prev)
				falls++;
			if (pix)
				pix_cycles++;
			if (!blank)
				shown_cycles++;
			vs_prev  = vsync;
			int_prev = int_n;
			@(negedge clk);
		end
		assert (clk_cnt - rise_at == FRAME_CLK)
			else stop_run($sformatf("** Error at %0t: frame %0d clk", $time, clk_cnt - rise_at));
		assert (fall_at - rise_at == VSYNC_CLK)
			else stop_run($sformatf("** Error at %0t: vsync high %0d clk", $time,
				fall_at - rise_at));
		assert (falls == (int_on ? 1 : 0) && low_cycles == (int_on ? INT_CLK : 0))
			else stop_run($sformatf("** Error at %0t: int_n fell %0d times, low %0d clk",
				$time, falls, low_cycles));
		assert (pix_cycles == PIX_CLK)
			else stop_run($sformatf("** Error at %0t: pix high %0d clk in a frame", $time,
				pix_cycles));
		assert (shown_cycles == SHOWN_CLK)
			else stop_run($sformatf("** Error at %0t: blank low %0d clk in a frame", $time,
				shown_cycles));
		apb_read(ADDR_FRAME, f1);
		assert (f1 == f0 + 32'd1)
			else stop_run($sformatf("** Error at %0t: FRAME %0d then %0d", $time, f0, f1));
	endtask

	task automatic check_frames_and_interrupt();
		watch_frame(1'b0);
		apb_write(ADDR_CTRL, 32'h1);
		watch_frame(1'b1);
	endtask

	task automatic check_resync();
		int edge_k, cend_k, expect_at;
		@(negedge clk);
		while (!hsync) @(negedge clk);
		while (hsync) @(negedge clk); // count now well past HSYNC_BEG
		apb_write(ADDR_CTRL, 32'h2);
		edge_k = last_write_edge - reset_edge; // init high in the cycle after this edge
		// cend is sampled on edges 5, 9, 13 ... after reset release
		cend_k = edge_k + ((`CLK_PER_CEND - (edge_k % `CLK_PER_CEND)) % `CLK_PER_CEND) + 1;
		expect_at = reset_edge + cend_k + (`HSYNC_BEG + 1) * `CLK_PER_CEND;
		@(negedge clk);
		while (!hsync) @(negedge clk);
		assert (clk_cnt == expect_at)
			else stop_run($sformatf("** Error at %0t: hsync rose at edge %0d, expected %0d",
				$time, clk_cnt, expect_at));
	endtask

	initial
	begin
		reset   = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		reset_edge = clk_cnt;
		check_reset_state();
		check_registers();
		check_line_timing();
		check_frames_and_interrupt();
		check_frame_clear();
		check_resync();
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
rtl/video_timing_pkg.sv
rtl/video_apb_pkg.sv
rtl/line_strobe_if.sv
rtl/video_strobes.sv
rtl/hsync_gen.sv
rtl/vsync_gen.sv
rtl/video_regs.sv
rtl/video_timing_top.sv
dv/video_timing_tb.sv

//--- Makefile
# Verilator build and run for the video timing testbench

VERILATOR ?= verilator
TOP       ?= video_timing_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
